//--- rbz_renderer.f
hw/rbz_pkg.sv
hw/rbz_vga_timing.sv
hw/rbz_reg_spi.sv
hw/rbz_tex_qspi.sv
hw/rbz_row_shader.sv
hw/rbz_renderer.sv
dv/tb_rbz_renderer.sv

//--- Makefile
# Verilator build and run for the renderer testbench

VERILATOR ?= verilator
TOP       ?= tb_rbz_renderer
FLIST     ?= rbz_renderer.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv) $(wildcard dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status of the simulation is the test result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/rbz_golden.txt
// kind f0 f1 f2 f3 f4 f5, kind 1 write: index payload nbits
// kind 2 lines: {wall,side,texu} size step init seed count, kind 3 expect: sky floor vshift vinf idx addend
2 085 064 000400 000000 33 3
1 0 3C 0A 0 0 0
1 5 012340 1C 0 0 0
1 0 15 0B 0 0 0
1 1 07 09 0 0 0
3 3C 2A 00 0 1 012340
2 16A 0C8 000180 3FE000 5A 258
1 2 05 0A 0 0 0
1 3 1 05 0 0 0
1 7 0ABCD0 1C 0 0 0
3 3C 2A 05 1 3 0ABCD0
2 151 140 000200 3F0000 A7 21C
2 03F 000 000100 000000 C3 2
2 1C0 0F0 3FFF00 002000 19 3
0 0 0 0 0 0 0

//--- dv/tb_rbz_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rbz_renderer;
  import rbz_pkg::*;

  localparam int REC_WORDS = 7;
  localparam int MAX_RECS  = 32;
  localparam int LINE_WAIT = 2 * H_TOTAL;

  logic       clk;
  logic       i_rst_n;
  logic       reg_ss_n;
  logic       reg_sclk;
  logic       reg_mosi;
  logic [1:0] wall_id;
  logic       side;
  logic [5:0] texu;
  logic [10:0] size;
  fix_t       tex_step;
  fix_t       tex_init;
  logic [3:0] tex_in;
  logic       tex_csb;
  logic       tex_sclk;
  logic       tex_out0;
  logic       tex_oeb0;
  logic       hsync_n;
  logic       vsync_n;
  rgb_t       rgb;
  logic       hblank;
  logic       vblank;
  logic       vinf;

  // Golden records and reference state
  logic [31:0] golden [MAX_RECS*REC_WORDS];
  int          h_ref;
  int          v_ref;
  logic [1:0]  m_wall;
  logic        m_side;
  logic [5:0]  m_texu;
  int          m_size;
  fix_t        m_step;
  fix_t        m_init;
  rgb_t        act_sky;
  rgb_t        act_floor;
  logic [5:0]  act_vshift;
  logic        act_vinf;
  tex_addr_t   act_texadd [4];
  logic        pend_valid;
  rgb_t        pend_sky;
  rgb_t        pend_floor;
  logic [5:0]  pend_vshift;
  logic        pend_vinf;
  logic [1:0]  pend_idx;
  tex_addr_t   pend_addend;
  logic [15:0] lfsr_q;
  logic [2:0]  tex_lo [TEXELS];
  logic [2:0]  tex_hi [TEXELS];
  logic [31:0] out_bits;
  logic        px_valid;
  rgb_t        px_exp;

  rbz_renderer dut0 (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_reg_ss_n (reg_ss_n),
    .i_reg_sclk (reg_sclk),
    .i_reg_mosi (reg_mosi),
    .i_wall_id  (wall_id),
    .i_side     (side),
    .i_texu     (texu),
    .i_size     (size),
    .i_tex_step (tex_step),
    .i_tex_init (tex_init),
    .i_tex_in   (tex_in),
    .o_tex_csb  (tex_csb),
    .o_tex_sclk (tex_sclk),
    .o_tex_out0 (tex_out0),
    .o_tex_oeb0 (tex_oeb0),
    .o_hsync_n  (hsync_n),
    .o_vsync_n  (vsync_n),
    .o_rgb      (rgb),
    .o_hblank   (hblank),
    .o_vblank   (vblank),
    .o_vinf     (vinf)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("Error: %s at %0t", msg, $time);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      abort_run("colour mismatch");
    end
  endtask

  task automatic check_addr(input string name, input tex_addr_t got, input tex_addr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      abort_run("flash preamble mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      abort_run("level mismatch");
    end
  endtask

  // Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Slice address: base from wall slot, side and texu plus the addend
  function automatic tex_addr_t slice_ref();
    logic [1:0] sel;
    sel = m_wall - 2'd1;
    slice_ref = {9'd0, sel, m_side, m_texu, 6'd0} + act_texadd[sel];
  endfunction

  // Pixel for the current position from the column and register model
  function automatic rgb_t expected_pixel();
    fix_t       sum;
    logic [5:0] tv;
    rgb_t       px;
    if (h_ref >= H_VIEW || v_ref >= V_VIEW) begin
      px = '0;
    end else if (h_ref + m_size >= HALF_SIZE && h_ref < HALF_SIZE + m_size) begin
      sum = m_init + fix_t'({act_vshift, {(FIX_FRAC + 3){1'b0}}}) + fix_t'(h_ref * m_step);
      // Underflow clamps to texel 0 unless vinf
      tv = (sum >= 0 || act_vinf) ? sum[FIX_FRAC+8:FIX_FRAC+3] : 6'd0;
      for (int ch = 0; ch < 3; ch++) begin
        px[2*ch]     = tex_lo[tv][ch];
        px[2*ch + 1] = tex_hi[tv][ch];
      end
    end else begin
      px = (h_ref < HALF_SIZE) ? act_floor : act_sky;
    end
    return px;
  endfunction

  // Reference position, descriptor latches and frame-end commit
  always @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      h_ref = 0;
      v_ref = 0;
    end else begin
      if (h_ref == TSPI_START) begin
        m_wall = wall_id;
        m_side = side;
        m_texu = texu;
      end
      if (h_ref == H_TOTAL - 1) begin
        m_size = int'(size);
        m_step = tex_step;
        m_init = tex_init;
        if (v_ref == V_VIEW - 1 && pend_valid) begin
          act_sky                = pend_sky;
          act_floor              = pend_floor;
          act_vshift             = pend_vshift;
          act_vinf               = pend_vinf;
          act_texadd[pend_idx]   = pend_addend;
          pend_valid             = 1'b0;
        end
        h_ref = 0;
        v_ref = (v_ref == V_TOTAL - 1) ? 0 : v_ref + 1;
      end else begin
        h_ref = h_ref + 1;
      end
    end
  end

  // Flash model, three LFSR bits per nibble, io3 idle
  always @(posedge clk) begin
    int         st;
    logic [2:0] nib;
    #1;
    st = (h_ref - TSPI_START) & 1023;
    if (i_rst_n && st >= TSPI_PREAMBLE_LEN && st < TSPI_STREAM_LEN) begin
      for (int b = 0; b < 3; b++) begin
        nib[b] = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
      end
      tex_in = {1'b0, nib};
      if (st % 2 == 0) begin
        tex_lo[(st - TSPI_PREAMBLE_LEN) >> 1] = nib;
      end else begin
        tex_hi[(st - TSPI_PREAMBLE_LEN) >> 1] = nib;
      end
    end else begin
      tex_in = 4'h0;
    end
  end

  // Flash clock is the inverted system clock, checked in both phases
  always @(clk) begin
    #1;
    check_bit("o_tex_sclk", tex_sclk, !clk);
  end

  // Output monitor at the falling edge, mid-cycle
  always @(negedge clk) begin
    int st;
    if (!i_rst_n) begin
      px_valid = 1'b0;
    end else begin
      check_bit("o_hsync_n", hsync_n, !(h_ref >= H_SYNC_START && h_ref < H_SYNC_END));
      check_bit("o_vsync_n", vsync_n, !(v_ref >= V_SYNC_START && v_ref < V_SYNC_END));
      check_bit("o_hblank", hblank, h_ref >= H_VIEW);
      check_bit("o_vblank", vblank, v_ref >= V_VIEW);
      check_bit("o_vinf", vinf, act_vinf);
      st = (h_ref - TSPI_START) & 1023;
      check_bit("o_tex_csb", tex_csb, st >= TSPI_STREAM_LEN);
      check_bit("o_tex_oeb0", tex_oeb0, st >= 32 && st < TSPI_STREAM_LEN);
      // Command and address are recorded, then compared as words
      if (st < 32) begin
        out_bits = {out_bits[30:0], tex_out0};
      end else begin
        check_bit("o_tex_out0", tex_out0, 1'b0);
      end
      if (st == 31) begin
        check_addr("tex command", {16'd0, out_bits[31:24]}, {16'd0, TSPI_CMD});
        check_addr("tex address", out_bits[23:0], slice_ref());
      end
      // Colour is registered, one cycle behind the position
      if (px_valid) begin
        check_rgb("o_rgb", rgb, px_exp);
      end
      px_exp   = expected_pixel();
      px_valid = 1'b1;
    end
  end

  task automatic hold_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Steps at least one cycle, then loops until the line position
  task automatic wait_hpos(input int target);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
      if (n > LINE_WAIT) begin
        abort_run("timed out waiting for a line position");
      end
    end while (h_ref != target);
  endtask

  // SPI mode 0, index then payload, sclk at clk/8
  task automatic send_reg(input logic [3:0] idx, input logic [27:0] payload, input int nbits);
    logic [31:0] word;
    word     = ({28'd0, idx} << (nbits - 4)) | {4'd0, payload};
    reg_ss_n = 1'b0;
    hold_cycles(4);
    for (int k = nbits - 1; k >= 0; k--) begin
      reg_mosi = word[k];
      reg_sclk = 1'b0;
      hold_cycles(4);
      reg_sclk = 1'b1;
      hold_cycles(4);
    end
    reg_sclk = 1'b0;
    hold_cycles(4);
    reg_ss_n = 1'b1;
    reg_mosi = 1'b0;
    hold_cycles(8);
  endtask

  // Descriptor held from hpos 599 on, for a number of lines
  task automatic run_lines(input logic [31:0] f0, input logic [31:0] f1,
                           input logic [31:0] f2, input logic [31:0] f3,
                           input logic [31:0] f4, input int count);
    for (int i = 0; i < count; i++) begin
      wait_hpos(TSPI_START - 1);
      wall_id  = f0[8:7];
      side     = f0[6];
      texu     = f0[5:0];
      size     = f1[10:0];
      tex_step = f2[21:0];
      tex_init = f3[21:0];
      if (i == 0) begin
        lfsr_q = f4[15:0];
      end
    end
  endtask

  initial begin
    int r;
    int base;
    clk        = 1'b0;
    i_rst_n    = 1'b0;
    reg_ss_n   = 1'b1;
    reg_sclk   = 1'b0;
    reg_mosi   = 1'b0;
    wall_id    = '0;
    side       = 1'b0;
    texu       = '0;
    size       = '0;
    tex_step   = '0;
    tex_init   = '0;
    tex_in     = '0;
    m_size     = 0;
    m_step     = '0;
    m_init     = '0;
    act_sky    = SKY_RESET;
    act_floor  = FLOOR_RESET;
    act_vshift = '0;
    act_vinf   = 1'b0;
    act_texadd = '{default: '0};
    pend_valid = 1'b0;
    lfsr_q     = 16'd51;
    out_bits   = '0;
    px_valid   = 1'b0;
    $readmemh("dv/rbz_golden.txt", golden);
    repeat (2) @(posedge clk);
    #1;
    i_rst_n = 1'b1;
    r = 0;
    while (golden[r*REC_WORDS] != 32'd0) begin
      base = r * REC_WORDS;
      case (golden[base])
        32'd1: send_reg(golden[base+1][3:0], golden[base+2][27:0], int'(golden[base+3]));
        32'd2: run_lines(golden[base+1], golden[base+2], golden[base+3],
                         golden[base+4], golden[base+5], int'(golden[base+6]));
        32'd3: begin
          // Values that the next frame end must make visible
          pend_sky    = golden[base+1][5:0];
          pend_floor  = golden[base+2][5:0];
          pend_vshift = golden[base+3][5:0];
          pend_vinf   = golden[base+4][0];
          pend_idx    = golden[base+5][1:0];
          pend_addend = golden[base+6][23:0];
          pend_valid  = 1'b1;
        end
        default: abort_run("unknown record kind in golden file");
      endcase
      r++;
      if (r >= MAX_RECS) begin
        abort_run("golden file has no end record");
      end
    end
    if (pend_valid) begin
      abort_run("expected register values were never committed");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

  // Run limit well above the golden sequence length
  initial begin
    #20000000;
    abort_run("simulation ran past its time limit");
  end

endmodule

`default_nettype wire

//--- hw/rbz_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module rbz_renderer #(
  parameter int H_TOTAL     = rbz_pkg::H_TOTAL,
  parameter int V_TOTAL     = rbz_pkg::V_TOTAL,
  parameter int SYNC_STAGES = 2
) (
  input  logic          clk,
  input  logic          i_rst_n,
  // Register SPI port
  input  logic          i_reg_ss_n,
  input  logic          i_reg_sclk,
  input  logic          i_reg_mosi,
  // Column descriptor for the next line
  input  logic [1:0]    i_wall_id,
  input  logic          i_side,
  input  logic [5:0]    i_texu,
  input  logic [10:0]   i_size,
  input  rbz_pkg::fix_t i_tex_step,
  input  rbz_pkg::fix_t i_tex_init,
  // Texture flash, QSPI
  input  logic [3:0]    i_tex_in,
  output logic          o_tex_csb,
  output logic          o_tex_sclk,
  output logic          o_tex_out0,
  output logic          o_tex_oeb0,
  // VGA
  output logic          o_hsync_n,
  output logic          o_vsync_n,
  output rbz_pkg::rgb_t o_rgb,
  output logic          o_hblank,
  output logic          o_vblank,
  output logic          o_vinf
);
  import rbz_pkg::*;

  pos_t       hpos;
  pos_t       vpos;
  logic       hsync;
  logic       vsync;
  logic       hmax;
  logic       frame_end;
  rgb_t       sky;
  rgb_t       floor_rgb;
  logic [5:0] vshift;
  tex_addr_t  texadd0;
  tex_addr_t  texadd1;
  tex_addr_t  texadd2;
  tex_addr_t  texadd3;
  logic [5:0] texv;
  rgb_t       texel_rgb;

  rbz_vga_timing #(
    .H_TOTAL (H_TOTAL),
    .V_TOTAL (V_TOTAL)
  ) u_timing (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .o_hpos      (hpos),
    .o_vpos      (vpos),
    .o_hsync     (hsync),
    .o_vsync     (vsync),
    .o_hblank    (o_hblank),
    .o_vblank    (o_vblank),
    .o_hmax      (hmax),
    .o_frame_end (frame_end)
  );

  // VGA syncs are active low
  assign o_hsync_n = ~hsync;
  assign o_vsync_n = ~vsync;

  // Settings land only between frames
  rbz_reg_spi #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_regs (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_ss_n      (i_reg_ss_n),
    .i_sclk      (i_reg_sclk),
    .i_mosi      (i_reg_mosi),
    .i_frame_end (frame_end),
    .o_sky       (sky),
    .o_floor     (floor_rgb),
    .o_vshift    (vshift),
    .o_vinf      (o_vinf),
    .o_texadd0   (texadd0),
    .o_texadd1   (texadd1),
    .o_texadd2   (texadd2),
    .o_texadd3   (texadd3)
  );

  // Fetches next line's slice during blanking
  rbz_tex_qspi u_tex (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_hpos      (hpos),
    .i_wall_id   (i_wall_id),
    .i_side      (i_side),
    .i_texu      (i_texu),
    .i_texadd0   (texadd0),
    .i_texadd1   (texadd1),
    .i_texadd2   (texadd2),
    .i_texadd3   (texadd3),
    .i_texv      (texv),
    .i_tex_in    (i_tex_in),
    .o_tex_csb   (o_tex_csb),
    .o_tex_sclk  (o_tex_sclk),
    .o_tex_out0  (o_tex_out0),
    .o_tex_oeb0  (o_tex_oeb0),
    .o_texel_rgb (texel_rgb)
  );

  rbz_row_shader u_shader (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_hpos      (hpos),
    .i_vpos      (vpos),
    .i_hmax      (hmax),
    .i_size      (i_size),
    .i_tex_step  (i_tex_step),
    .i_tex_init  (i_tex_init),
    .i_vshift    (vshift),
    .i_vinf      (o_vinf),
    .i_sky       (sky),
    .i_floor     (floor_rgb),
    .i_texel_rgb (texel_rgb),
    .o_texv      (texv),
    .o_rgb       (o_rgb)
  );

endmodule

`default_nettype wire

//--- hw/rbz_row_shader.sv
`timescale 1ns/1ps
`default_nettype none

module rbz_row_shader (
  input  logic          clk,
  input  logic          i_rst_n,
  input  rbz_pkg::pos_t i_hpos,
  input  rbz_pkg::pos_t i_vpos,
  input  logic          i_hmax,
  input  logic [10:0]   i_size,
  input  rbz_pkg::fix_t i_tex_step,
  input  rbz_pkg::fix_t i_tex_init,
  input  logic [5:0]    i_vshift,
  input  logic          i_vinf,
  input  rbz_pkg::rgb_t i_sky,
  input  rbz_pkg::rgb_t i_floor,
  input  rbz_pkg::rgb_t i_texel_rgb,
  output logic [5:0]    o_texv,
  output rbz_pkg::rgb_t o_rgb
);
  import rbz_pkg::*;

  logic [10:0] size_q;
  fix_t        step_q;
  fix_t        init_q;
  fix_t        acc_q;
  fix_t        vshift_fix;
  fix_t        sum;
  logic [11:0] hpos_ext;
  logic [11:0] size_ext;
  logic        in_wall;
  logic        blank;
  rgb_t        bg;

  // Descriptor for the coming line
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      size_q <= '0;
    end else if (i_hmax) begin
      size_q <= i_size;
    end
  end

  always_ff @(posedge clk) begin
    if (i_hmax) begin
      step_q <= i_tex_step;
      init_q <= i_tex_init;
    end
  end

  // Texture v accumulator, zero at hpos 0
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      acc_q <= '0;
    end else begin
      acc_q <= i_hmax ? '0 : acc_q + step_q;
    end
  end

  // Shift in whole texels, 8 screen pixels per texel at unit distance
  assign vshift_fix = fix_t'({i_vshift, {(FIX_FRAC + 3){1'b0}}});
  assign sum        = acc_q + init_q + vshift_fix;

  // Clamp underflow to the first texel
  // vinf lets negative values wrap instead
  assign o_texv = (!sum[$bits(fix_t)-1] || i_vinf) ?
                  sum[FIX_FRAC+8:FIX_FRAC+3] : 6'd0;

  // Wall span is centred on HALF_SIZE, 12 bits avoid going negative
  assign hpos_ext = {2'b00, i_hpos};
  assign size_ext = {1'b0, size_q};
  assign in_wall  = (hpos_ext + size_ext >= 12'(HALF_SIZE)) &&
                    (hpos_ext < 12'(HALF_SIZE) + size_ext);

  assign blank = (i_hpos >= pos_t'(H_VIEW)) || (i_vpos >= pos_t'(V_VIEW));

  // Floor on the low half of the column, sky on the high half
  assign bg = (i_hpos < pos_t'(HALF_SIZE)) ? i_floor : i_sky;

  // Registered pixel colour
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rgb <= '0;
    end else if (blank) begin
      o_rgb <= '0;
    end else if (in_wall) begin
      o_rgb <= i_texel_rgb;
    end else begin
      o_rgb <= bg;
    end
  end

endmodule

`default_nettype wire

//--- hw/rbz_tex_qspi.sv
`timescale 1ns/1ps
`default_nettype none

module rbz_tex_qspi (
  input  logic               clk,
  input  logic               i_rst_n,
  input  rbz_pkg::pos_t      i_hpos,
  input  logic [1:0]         i_wall_id,
  input  logic               i_side,
  input  logic [5:0]         i_texu,
  input  rbz_pkg::tex_addr_t i_texadd0,
  input  rbz_pkg::tex_addr_t i_texadd1,
  input  rbz_pkg::tex_addr_t i_texadd2,
  input  rbz_pkg::tex_addr_t i_texadd3,
  input  logic [5:0]         i_texv,
  input  logic [3:0]         i_tex_in,
  output logic               o_tex_csb,
  output logic               o_tex_sclk,
  output logic               o_tex_out0,
  output logic               o_tex_oeb0,
  output rbz_pkg::rgb_t      o_texel_rgb
);
  import rbz_pkg::*;

  // First state after command and address
  localparam int ADDR_END = TSPI_CMD_LEN + TSPI_ADDR_LEN;

  pos_t              state;
  logic              streaming;
  logic              data_present;
  logic [1:0]        wall_sel_q;
  logic              side_q;
  logic [5:0]        texu_q;
  tex_addr_t         addend;
  tex_addr_t         slice_addr;
  logic [4:0]        addr_bit;
  // Planes 0..5 are red lo/hi, green lo/hi, blue lo/hi
  logic [TEXELS-1:0] plane_q [6];

  // Stream state follows hpos, wraps modulo 1024
  assign state        = i_hpos - pos_t'(TSPI_START);
  assign streaming    = (state < pos_t'(TSPI_STREAM_LEN));
  assign data_present = streaming && (state >= pos_t'(TSPI_PREAMBLE_LEN));

  // Flash clock runs continuously
  // Data set up on rising clk is stable at the rising SCLK edge
  assign o_tex_sclk = ~clk;

  // Chip select covers the whole stream
  assign o_tex_csb = !streaming;

  // io0 turns around at the dummy cycles
  assign o_tex_oeb0 = streaming && (state >= pos_t'(ADDR_END));

  // Capture the slice fields when the stream opens
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wall_sel_q <= '0;
      side_q     <= 1'b0;
      texu_q     <= '0;
    end else if (state == '0) begin
      // Wall ids 1..4 map to texture slots 0..3
      wall_sel_q <= i_wall_id - 2'd1;
      side_q     <= i_side;
      texu_q     <= i_texu;
    end
  end

  // Per-texture offset into flash
  always_comb begin
    case (wall_sel_q)
      2'd0:    addend = i_texadd0;
      2'd1:    addend = i_texadd1;
      2'd2:    addend = i_texadd2;
      default: addend = i_texadd3;
    endcase
  end

  // 64 bytes per slice, texu picks the slice
  // Side and wall slot sit above it
  assign slice_addr = {9'd0, wall_sel_q, side_q, texu_q, 6'd0} + addend;

  // Address goes out MSB first from state 8
  assign addr_bit = 5'(ADDR_END - 1) - state[4:0];

  always_comb begin
    if (state < pos_t'(TSPI_CMD_LEN)) begin
      o_tex_out0 = TSPI_CMD[3'd7 - state[2:0]];
    end else if (state < pos_t'(ADDR_END)) begin
      o_tex_out0 = slice_addr[addr_bit];
    end else begin
      // Dummy cycles, read phase and idle
      o_tex_out0 = 1'b0;
    end
  end

  // Sample on the rising SCLK edge, where flash data is stable
  // Even states carry the low colour bits, odd states the high bits
  // io3 is not used
  always_ff @(negedge clk) begin
    if (data_present) begin
      for (int ch = 0; ch < 3; ch++) begin
        plane_q[2*ch + state[0]] <=
          {i_tex_in[ch], plane_q[2*ch + state[0]][TEXELS-1:1]};
      end
    end
  end

  // Bit k of the colour comes from plane k
  always_comb begin
    for (int k = 0; k < 6; k++) begin
      o_texel_rgb[k] = plane_q[k][i_texv];
    end
  end

  // Turnaround only inside a select window that opened with the command
  a_oeb_in_window: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    o_tex_oeb0 |-> !o_tex_csb && $past(!o_tex_csb, ADDR_END)
  );

endmodule

`default_nettype wire

//--- hw/rbz_reg_spi.sv
`timescale 1ns/1ps
`default_nettype none

module rbz_reg_spi #(
  parameter int SYNC_STAGES = 2
) (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_ss_n,
  input  logic               i_sclk,
  input  logic               i_mosi,
  input  logic               i_frame_end,
  output rbz_pkg::rgb_t      o_sky,
  output rbz_pkg::rgb_t      o_floor,
  output logic [5:0]         o_vshift,
  output logic               o_vinf,
  output rbz_pkg::tex_addr_t o_texadd0,
  output rbz_pkg::tex_addr_t o_texadd1,
  output rbz_pkg::tex_addr_t o_texadd2,
  output rbz_pkg::tex_addr_t o_texadd3
);
  import rbz_pkg::*;

  // Longest transfer is index plus a 24-bit addend
  localparam int SR_LEN = 4 + 24;

  logic [SYNC_STAGES-1:0][2:0] sync_q;
  logic                        ss_n_s;
  logic                        sclk_s;
  logic                        mosi_s;
  logic                        ss_n_d;
  logic                        sclk_d;
  logic                        sclk_rise;
  logic                        xfer_end;
  logic [5:0]                  bit_cnt;
  logic [SR_LEN-1:0]           shift_q;
  reg_idx_e                    idx;
  logic [5:0]                  width;
  logic                        stage_ok;
  rgb_t                        sky_st;
  rgb_t                        floor_st;
  logic [5:0]                  vshift_st;
  logic                        vinf_st;
  tex_addr_t                   texadd_st [4];

  // Payload width per register, 0 for an unknown index
  function automatic logic [5:0] payload_width(input reg_idx_e i);
    case (i)
      SKY, FLOOR, VSHIFT:                 payload_width = 6'd6;
      VINF:                               payload_width = 6'd1;
      TEXADD0, TEXADD1, TEXADD2, TEXADD3: payload_width = 6'd24;
      default:                            payload_width = 6'd0;
    endcase
  endfunction

  // Two-flop style synchronisers, ss_n idles high
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sync_q <= {SYNC_STAGES{3'b100}};
      ss_n_d <= 1'b1;
      sclk_d <= 1'b0;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], {i_ss_n, i_sclk, i_mosi}};
      ss_n_d <= ss_n_s;
      sclk_d <= sclk_s;
    end
  end

  assign {ss_n_s, sclk_s, mosi_s} = sync_q[SYNC_STAGES-1];

  // Mode 0 samples on the rising sclk edge
  assign sclk_rise = sclk_s && !sclk_d;
  // Transfer closes when ss_n goes back high
  assign xfer_end  = ss_n_s && !ss_n_d;

  // Bit count saturates so long transfers never alias to a valid length
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      bit_cnt <= '0;
    end else if (ss_n_s) begin
      bit_cnt <= '0;
    end else if (sclk_rise && (bit_cnt != 6'h3F)) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // MSB first, the newest bit lands at bit 0
  always_ff @(posedge clk) begin
    if (!ss_n_s && sclk_rise) begin
      shift_q <= {shift_q[SR_LEN-2:0], mosi_s};
    end
  end

  // Index sits just above the payload, whatever its width
  assign idx      = reg_idx_e'(4'(shift_q >> (bit_cnt - 6'd4)));
  assign width    = payload_width(idx);
  assign stage_ok = (width != 6'd0) && (bit_cnt == 6'd4 + width);

  // Staged copies take every well-formed write
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sky_st    <= SKY_RESET;
      floor_st  <= FLOOR_RESET;
      vshift_st <= '0;
      vinf_st   <= 1'b0;
      texadd_st <= '{default: '0};
    end else if (xfer_end && stage_ok) begin
      case (idx)
        SKY:     sky_st    <= shift_q[5:0];
        FLOOR:   floor_st  <= shift_q[5:0];
        VSHIFT:  vshift_st <= shift_q[5:0];
        VINF:    vinf_st   <= shift_q[0];
        // Only the four addends remain here
        default: texadd_st[idx[1:0]] <= shift_q[23:0];
      endcase
    end
  end

  // Active copies follow the staged ones once per frame
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_sky     <= SKY_RESET;
      o_floor   <= FLOOR_RESET;
      o_vshift  <= '0;
      o_vinf    <= 1'b0;
      o_texadd0 <= '0;
      o_texadd1 <= '0;
      o_texadd2 <= '0;
      o_texadd3 <= '0;
    end else if (i_frame_end) begin
      o_sky     <= sky_st;
      o_floor   <= floor_st;
      o_vshift  <= vshift_st;
      o_vinf    <= vinf_st;
      o_texadd0 <= texadd_st[0];
      o_texadd1 <= texadd_st[1];
      o_texadd2 <= texadd_st[2];
      o_texadd3 <= texadd_st[3];
    end
  end

  // No tearing inside a visible frame
  a_commit_at_frame_end: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    $changed({o_sky, o_floor, o_vshift, o_vinf,
              o_texadd0, o_texadd1, o_texadd2, o_texadd3})
      |-> $past(i_frame_end)
  );

endmodule

`default_nettype wire

//--- hw/rbz_vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module rbz_vga_timing #(
  parameter int H_TOTAL = rbz_pkg::H_TOTAL,
  parameter int V_TOTAL = rbz_pkg::V_TOTAL
) (
  input  logic          clk,
  input  logic          i_rst_n,
  output rbz_pkg::pos_t o_hpos,
  output rbz_pkg::pos_t o_vpos,
  output logic          o_hsync,
  output logic          o_vsync,
  output logic          o_hblank,
  output logic          o_vblank,
  output logic          o_hmax,
  output logic          o_frame_end
);
  import rbz_pkg::*;

  logic h_last;
  logic v_last;

  // Last column of a line and last line of a frame
  assign h_last = (o_hpos == pos_t'(H_TOTAL - 1));
  assign v_last = (o_vpos == pos_t'(V_TOTAL - 1));

  // Free-running position counters
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_hpos <= '0;
      o_vpos <= '0;
    end else if (h_last) begin
      o_hpos <= '0;
      // Vertical count steps once per line
      o_vpos <= v_last ? '0 : o_vpos + 1'b1;
    end else begin
      o_hpos <= o_hpos + 1'b1;
    end
  end

  // Sync pulses are active high here, top level inverts
  assign o_hsync = (o_hpos >= pos_t'(H_SYNC_START)) && (o_hpos < pos_t'(H_SYNC_END));
  assign o_vsync = (o_vpos >= pos_t'(V_SYNC_START)) && (o_vpos < pos_t'(V_SYNC_END));

  assign o_hblank = (o_hpos >= pos_t'(H_VIEW));
  assign o_vblank = (o_vpos >= pos_t'(V_VIEW));

  // Line end strobe
  assign o_hmax = h_last;
  // Last pixel slot of the last visible line
  assign o_frame_end = h_last && (o_vpos == pos_t'(V_VIEW - 1));

  // Horizontal count must wrap before it leaves the line
  a_hpos_range: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    o_hpos < pos_t'(H_TOTAL)
  );

endmodule

`default_nettype wire

//--- hw/rbz_pkg.sv
`default_nettype none

package rbz_pkg;

  // Default 640x480 timing, sync ends are exclusive
  localparam int H_VIEW       = 640;
  localparam int V_VIEW       = 480;
  localparam int H_TOTAL      = 800;
  localparam int V_TOTAL      = 525;
  localparam int H_SYNC_START = 656;
  localparam int H_SYNC_END   = 752;
  localparam int V_SYNC_START = 490;
  localparam int V_SYNC_END   = 492;

  // Screen-centre row of the rotated display
  localparam int HALF_SIZE = H_VIEW / 2;

  typedef logic [9:0] pos_t;

  // Blue pair, green pair, red pair from the top down
  typedef logic [5:0] rgb_t;

  // Signed fixed point with 10 fraction bits
  localparam int FIX_FRAC = 10;
  typedef logic signed [21:0] fix_t;

  typedef logic [23:0] tex_addr_t;

  // Texture slice stream, one byte per texel
  localparam int         TEXELS            = 64;
  localparam logic [7:0] TSPI_CMD          = 8'h6B;
  localparam int         TSPI_CMD_LEN      = 8;
  localparam int         TSPI_ADDR_LEN     = 24;
  localparam int         TSPI_DUMMY_LEN    = 8;
  localparam int         TSPI_PREAMBLE_LEN = TSPI_CMD_LEN + TSPI_ADDR_LEN + TSPI_DUMMY_LEN;
  localparam int         TSPI_STREAM_LEN   = TSPI_PREAMBLE_LEN + 2 * TEXELS;
  // Preamble ends exactly at the start of horizontal blanking
  localparam int         TSPI_START        = H_VIEW - TSPI_PREAMBLE_LEN;

  // Register port index
  typedef enum logic [3:0] {
    SKY     = 4'd0,
    FLOOR   = 4'd1,
    VSHIFT  = 4'd2,
    VINF    = 4'd3,
    TEXADD0 = 4'd4,
    TEXADD1 = 4'd5,
    TEXADD2 = 4'd6,
    TEXADD3 = 4'd7
  } reg_idx_e;

  localparam rgb_t SKY_RESET   = 6'b010101;
  localparam rgb_t FLOOR_RESET = 6'b101010;

endpackage

`default_nettype wire
